/* design/kd_tree_config.svh */
/*
 widths and depths of the kd-tree search stage
 patch element and patch widths
 tree depth and internal node count
 leaf index, node address and node word widths
*/
`ifndef KD_TREE_CONFIG_SVH
`define KD_TREE_CONFIG_SVH

// one patch element, also one half of a node word
`define KD_ELEM_WIDTH 11
// elements per patch
`define KD_ELEMS 5
`define KD_PATCH_WIDTH 55

// six levels of internal nodes, heap ordered
`define KD_DEPTH 6
`define KD_NODES 63

// leaf index after the last level
`define KD_LEAF_WIDTH 6
`define KD_NODE_ADDR_WIDTH 6
// split index over median
`define KD_NODE_WIDTH 22

`endif

/* design/kd_tree_pkg.sv */
/*
 shared types of the kd-tree search stage
 node word layout, host port opcodes, node load modes
*/
`include "kd_tree_config.svh"

package kd_tree_pkg;

    // upper half split index, lower half median
    // only idx[2:0] is looked at by a node
    typedef struct packed {
        logic [`KD_NODE_WIDTH-`KD_ELEM_WIDTH-1:0] idx;
        logic [`KD_ELEM_WIDTH-1:0]                median;
    } node_word_t;

    // host port operations
    // write lo holds the median, write hi commits the whole node
    typedef enum logic [1:0] {
        CFG_WR_LO = 2'd0,
        CFG_WR_HI = 2'd1,
        CFG_RD_LO = 2'd2,
        CFG_RD_HI = 2'd3
    } cfg_op_e;

    // who owns the node write port
    typedef enum logic {
        MODE_STREAM = 1'b0,
        MODE_HOST   = 1'b1
    } load_mode_e;

endpackage

/* design/internal_node.sv */
/*
 one internal node of the kd-tree
 node word register, element select and median compare
 path valid split into left and right for both lanes
*/
`timescale 1ns/1ns
`include "kd_tree_config.svh"

module internal_node (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       we_i,
    input  kd_tree_pkg::node_word_t    wdata_i,
    input  logic [`KD_PATCH_WIDTH-1:0] patch_i,
    input  logic                       path_valid_i,
    input  logic [`KD_PATCH_WIDTH-1:0] patch_two_i,
    input  logic                       path_two_valid_i,
    output logic                       left_o,
    output logic                       right_o,
    output logic                       left_two_o,
    output logic                       right_two_o,
    output kd_tree_pkg::node_word_t    rdata_o
);
    import kd_tree_pkg::*;

    node_word_t                word_q;
    logic [2:0]                sel;
    logic [`KD_ELEM_WIDTH-1:0] elem;
    logic [`KD_ELEM_WIDTH-1:0] elem_two;
    logic                      go_left;
    logic                      go_left_two;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_q <= '0;
        end else if (we_i) begin
            word_q <= wdata_i;
        end
    end

    // index past the last element clamps to it
    assign sel = (word_q.idx[2:0] > 3'(`KD_ELEMS - 1)) ? 3'(`KD_ELEMS - 1) : word_q.idx[2:0];

    // same element for both lanes, each lane its own patch
    assign elem     = patch_i[sel*`KD_ELEM_WIDTH +: `KD_ELEM_WIDTH];
    assign elem_two = patch_two_i[sel*`KD_ELEM_WIDTH +: `KD_ELEM_WIDTH];

    // below the median goes left, equal or above goes right
    assign go_left     = elem < word_q.median;
    assign go_left_two = elem_two < word_q.median;

    assign left_o      = path_valid_i & go_left;
    assign right_o     = path_valid_i & ~go_left;
    assign left_two_o  = path_two_valid_i & go_left_two;
    assign right_two_o = path_two_valid_i & ~go_left_two;

    assign rdata_o = word_q;

endmodule

/* design/node_loader.sv */
/*
 node write source for the kd-tree
 stream address counter with restart
 host port half-word assembly, read mux and ack
 stream and host writes selected by the load mode
*/
`timescale 1ns/1ns
`include "kd_tree_config.svh"

module node_loader (
    input  logic                           clk,
    input  logic                           rst_n,
    input  kd_tree_pkg::load_mode_e        mode_i,
    input  logic                           node_wr_i,
    input  kd_tree_pkg::node_word_t        node_data_i,
    input  logic                           load_restart_i,
    input  logic                           cfg_stb_i,
    input  kd_tree_pkg::cfg_op_e           cfg_op_i,
    input  logic [`KD_NODE_ADDR_WIDTH-1:0] cfg_addr_i,
    input  logic [`KD_ELEM_WIDTH-1:0]      cfg_data_i,
    output logic                           cfg_ack_o,
    output logic [`KD_ELEM_WIDTH-1:0]      cfg_rdata_o,
    output logic                           node_we_o,
    output logic [`KD_NODE_ADDR_WIDTH-1:0] node_waddr_o,
    output kd_tree_pkg::node_word_t        node_wdata_o,
    output logic [`KD_NODE_ADDR_WIDTH-1:0] node_raddr_o,
    input  kd_tree_pkg::node_word_t        node_rdata_i
);
    import kd_tree_pkg::*;

    logic [`KD_NODE_ADDR_WIDTH-1:0] waddr_q;
    logic [`KD_ELEM_WIDTH-1:0]      med_q;
    logic                           ack_q;
    logic [`KD_ELEM_WIDTH-1:0]      rdata_q;
    logic [`KD_ELEM_WIDTH-1:0]      rdata_d;
    logic                           host_stb;
    logic                           host_we;
    logic                           stream_we;

    // host strobes only count in host mode
    assign host_stb = cfg_stb_i && (mode_i == MODE_HOST);
    assign host_we  = host_stb && (cfg_op_i == CFG_WR_HI);

    // stream write, dropped once the counter sits past the last node
    assign stream_we = node_wr_i && (mode_i == MODE_STREAM)
                       && (waddr_q != `KD_NODE_ADDR_WIDTH'(`KD_NODES));

    // write strobe straight to the nodes, lands on the sampling edge
    assign node_we_o    = stream_we || host_we;
    assign node_waddr_o = (mode_i == MODE_HOST) ? cfg_addr_i : waddr_q;
    assign node_wdata_o = (mode_i == MODE_HOST) ? {cfg_data_i, med_q} : node_data_i;

    // tree answers the host address combinationally
    assign node_raddr_o = cfg_addr_i;

    // read half select, zero for anything but a read
    always_comb begin
        rdata_d = '0;
        if (host_stb) begin
            case (cfg_op_i)
                CFG_RD_LO: rdata_d = node_rdata_i.median;
                CFG_RD_HI: rdata_d = node_rdata_i.idx;
                default:   rdata_d = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            waddr_q <= '0;
            med_q   <= '0;
            ack_q   <= 1'b0;
            rdata_q <= '0;
        end else begin
            // restart wins over a same-cycle increment
            if (load_restart_i) begin
                waddr_q <= '0;
            end else if (stream_we) begin
                waddr_q <= waddr_q + 1'b1;
            end
            // pending median until the hi half arrives
            if (host_stb && (cfg_op_i == CFG_WR_LO)) begin
                med_q <= cfg_data_i;
            end
            ack_q   <= host_stb;
            rdata_q <= rdata_d;
        end
    end

    assign cfg_ack_o   = ack_q;
    assign cfg_rdata_o = rdata_q;

endmodule

/* design/internal_node_tree.sv */
/*
 six-level kd-tree of internal nodes, two patch lanes
 per-level patch registers and heap-ordered path valid vectors
 strobe trackers for the seven cycle latency
 one-hot node write decode, node read mux, leaf encoders
*/
`timescale 1ns/1ns
`include "kd_tree_config.svh"

module internal_node_tree (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           patch_valid_i,
    input  logic [`KD_PATCH_WIDTH-1:0]     patch_i,
    input  logic                           patch_two_valid_i,
    input  logic [`KD_PATCH_WIDTH-1:0]     patch_two_i,
    input  logic                           node_we_i,
    input  logic [`KD_NODE_ADDR_WIDTH-1:0] node_waddr_i,
    input  kd_tree_pkg::node_word_t        node_wdata_i,
    input  logic [`KD_NODE_ADDR_WIDTH-1:0] node_raddr_i,
    output kd_tree_pkg::node_word_t        node_rdata_o,
    output logic                           leaf_valid_o,
    output logic [`KD_LEAF_WIDTH-1:0]      leaf_index_o,
    output logic                           leaf_two_valid_o,
    output logic [`KD_LEAF_WIDTH-1:0]      leaf_two_index_o
);
    import kd_tree_pkg::*;

    localparam int LANES = 2;
    // root, internal nodes and leaves in heap order
    localparam int PATH_BITS = 2 * `KD_NODES + 1;

    logic [`KD_PATCH_WIDTH-1:0] patch_in [LANES];
    logic [LANES-1:0]           strobe_in;
    // patch copy per level, level k feeds the nodes of level k
    logic [`KD_PATCH_WIDTH-1:0] patch_q [LANES][`KD_DEPTH];
    // bit a is the path valid into node a, leaves from bit 63 up
    wire  [PATH_BITS-1:0]       path_d [LANES];
    logic [PATH_BITS-1:0]       path_q [LANES];
    // seven stage strobe tracker per lane
    logic [`KD_DEPTH:0]         trk_q [LANES];
    logic [`KD_LEAF_WIDTH-1:0]  leaf_q [LANES];
    logic [`KD_NODES-1:0]       node_we_oh;
    node_word_t                 node_rd [`KD_NODES];

    // lowest set leaf bit, only one is ever set
    function automatic logic [`KD_LEAF_WIDTH-1:0] leaf_enc(input logic [`KD_NODES:0] v);
        logic [`KD_LEAF_WIDTH-1:0] idx;
        idx = '0;
        for (int i = `KD_NODES; i >= 0; i--) begin
            if (v[i]) begin
                idx = `KD_LEAF_WIDTH'(i);
            end
        end
        return idx;
    endfunction

    assign patch_in[0] = patch_i;
    assign patch_in[1] = patch_two_i;
    assign strobe_in   = {patch_two_valid_i, patch_valid_i};

    // root path valid is the lane strobe itself
    for (genvar l = 0; l < LANES; l++) begin : g_lane
        assign path_d[l][0] = strobe_in[l];
    end

    // write enable for a single node, address 63 hits nothing
    always_comb begin
        node_we_oh = '0;
        for (int a = 0; a < `KD_NODES; a++) begin
            node_we_oh[a] = node_we_i && (node_waddr_i == a);
        end
    end

    // node a drives children 2a+1 and 2a+2
    for (genvar k = 0; k < `KD_DEPTH; k++) begin : g_level
        for (genvar j = 0; j < (1 << k); j++) begin : g_node
            localparam int A = (1 << k) - 1 + j;

            internal_node u_node (
                .clk              (clk),
                .rst_n            (rst_n),
                .we_i             (node_we_oh[A]),
                .wdata_i          (node_wdata_i),
                .patch_i          (patch_q[0][k]),
                .path_valid_i     (path_q[0][A]),
                .patch_two_i      (patch_q[1][k]),
                .path_two_valid_i (path_q[1][A]),
                .left_o           (path_d[0][2*A+1]),
                .right_o          (path_d[0][2*A+2]),
                .left_two_o       (path_d[1][2*A+1]),
                .right_two_o      (path_d[1][2*A+2]),
                .rdata_o          (node_rd[A])
            );
        end
    end

    // payload pipeline, patches and encoded leaves
    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            patch_q[l][0] <= patch_in[l];
            for (int k = 1; k < `KD_DEPTH; k++) begin
                patch_q[l][k] <= patch_q[l][k-1];
            end
            // level six vector at n+6, leaf registered at n+7
            leaf_q[l] <= leaf_enc(path_q[l][PATH_BITS-1:`KD_NODES]);
        end
    end

    // control pipeline, path valids and trackers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int l = 0; l < LANES; l++) begin
                path_q[l] <= '0;
                trk_q[l]  <= '0;
            end
        end else begin
            for (int l = 0; l < LANES; l++) begin
                path_q[l] <= path_d[l];
                // root bit is the strobe taken at edge n
                trk_q[l]  <= {trk_q[l][`KD_DEPTH-1:0], path_q[l][0]};
            end
        end
    end

    // host read mux, address 63 reads zero
    always_comb begin
        node_rdata_o = '0;
        for (int a = 0; a < `KD_NODES; a++) begin
            if (node_raddr_i == a) begin
                node_rdata_o = node_rd[a];
            end
        end
    end

    assign leaf_valid_o     = trk_q[0][`KD_DEPTH];
    assign leaf_two_valid_o = trk_q[1][`KD_DEPTH];

    // index shown only alongside its valid
    assign leaf_index_o     = leaf_valid_o ? leaf_q[0] : '0;
    assign leaf_two_index_o = leaf_two_valid_o ? leaf_q[1] : '0;

endmodule

/* design/kd_tree_top.sv */
/*
 kd-tree search stage top level
 node loader for stream and host writes
 node tree with the two patch lanes
*/
`timescale 1ns/1ns
`include "kd_tree_config.svh"

module kd_tree_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  kd_tree_pkg::load_mode_e        mode_i,
    // node stream
    input  logic                           node_wr_i,
    input  kd_tree_pkg::node_word_t        node_data_i,
    input  logic                           load_restart_i,
    // host port
    input  logic                           cfg_stb_i,
    input  kd_tree_pkg::cfg_op_e           cfg_op_i,
    input  logic [`KD_NODE_ADDR_WIDTH-1:0] cfg_addr_i,
    input  logic [`KD_ELEM_WIDTH-1:0]      cfg_data_i,
    output logic                           cfg_ack_o,
    output logic [`KD_ELEM_WIDTH-1:0]      cfg_rdata_o,
    // patch lanes
    input  logic                           patch_valid_i,
    input  logic [`KD_PATCH_WIDTH-1:0]     patch_i,
    input  logic                           patch_two_valid_i,
    input  logic [`KD_PATCH_WIDTH-1:0]     patch_two_i,
    output logic                           leaf_valid_o,
    output logic [`KD_LEAF_WIDTH-1:0]      leaf_index_o,
    output logic                           leaf_two_valid_o,
    output logic [`KD_LEAF_WIDTH-1:0]      leaf_two_index_o
);

    logic                           node_we;
    logic [`KD_NODE_ADDR_WIDTH-1:0] node_waddr;
    kd_tree_pkg::node_word_t        node_wdata;
    logic [`KD_NODE_ADDR_WIDTH-1:0] node_raddr;
    kd_tree_pkg::node_word_t        node_rdata;

    node_loader u_loader (
        .clk            (clk),
        .rst_n          (rst_n),
        .mode_i         (mode_i),
        .node_wr_i      (node_wr_i),
        .node_data_i    (node_data_i),
        .load_restart_i (load_restart_i),
        .cfg_stb_i      (cfg_stb_i),
        .cfg_op_i       (cfg_op_i),
        .cfg_addr_i     (cfg_addr_i),
        .cfg_data_i     (cfg_data_i),
        .cfg_ack_o      (cfg_ack_o),
        .cfg_rdata_o    (cfg_rdata_o),
        .node_we_o      (node_we),
        .node_waddr_o   (node_waddr),
        .node_wdata_o   (node_wdata),
        .node_raddr_o   (node_raddr),
        .node_rdata_i   (node_rdata)
    );

    internal_node_tree u_tree (
        .clk               (clk),
        .rst_n             (rst_n),
        .patch_valid_i     (patch_valid_i),
        .patch_i           (patch_i),
        .patch_two_valid_i (patch_two_valid_i),
        .patch_two_i       (patch_two_i),
        .node_we_i         (node_we),
        .node_waddr_i      (node_waddr),
        .node_wdata_i      (node_wdata),
        .node_raddr_i      (node_raddr),
        .node_rdata_o      (node_rdata),
        .leaf_valid_o      (leaf_valid_o),
        .leaf_index_o      (leaf_index_o),
        .leaf_two_valid_o  (leaf_two_valid_o),
        .leaf_two_index_o  (leaf_two_index_o)
    );

endmodule

/* testbench/kd_tree_tb.sv */
/*
 testbench for the kd-tree search stage
 command file reader, stream and host port drivers
 per-lane expected leaf queues with latency check
 host acknowledge and read data monitor
 cycle limit from the command count
*/
`timescale 1ns/1ns
`include "kd_tree_config.svh"

module kd_tree_tb;
    import kd_tree_pkg::*;

    logic                           clk;
    logic                           rst_n;
    load_mode_e                     mode;
    logic                           node_wr;
    node_word_t                     node_data;
    logic                           load_restart;
    logic                           cfg_stb;
    cfg_op_e                        cfg_op;
    logic [`KD_NODE_ADDR_WIDTH-1:0] cfg_addr;
    logic [`KD_ELEM_WIDTH-1:0]      cfg_data;
    logic                           cfg_ack;
    logic [`KD_ELEM_WIDTH-1:0]      cfg_rdata;
    logic                           patch_valid;
    logic [`KD_PATCH_WIDTH-1:0]     patch;
    logic                           patch_two_valid;
    logic [`KD_PATCH_WIDTH-1:0]     patch_two;
    logic                           leaf_valid;
    logic [`KD_LEAF_WIDTH-1:0]      leaf_index;
    logic                           leaf_two_valid;
    logic [`KD_LEAF_WIDTH-1:0]      leaf_two_index;

    int          cyc = 0;
    int          limit = 1000000;
    int unsigned lcg_state = 67317;
    // cycle in which the host ack is due
    int          ack_due = -1;
    // expected leaf and due cycle, per lane
    int          exp_q [2][$];
    int          due_q [2][$];

    kd_tree_top dut0 (
        .clk (clk), .rst_n (rst_n), .mode_i (mode),
        .node_wr_i (node_wr), .node_data_i (node_data), .load_restart_i (load_restart),
        .cfg_stb_i (cfg_stb), .cfg_op_i (cfg_op), .cfg_addr_i (cfg_addr),
        .cfg_data_i (cfg_data), .cfg_ack_o (cfg_ack), .cfg_rdata_o (cfg_rdata),
        .patch_valid_i (patch_valid), .patch_i (patch),
        .patch_two_valid_i (patch_two_valid), .patch_two_i (patch_two),
        .leaf_valid_o (leaf_valid), .leaf_index_o (leaf_index),
        .leaf_two_valid_o (leaf_two_valid), .leaf_two_index_o (leaf_two_index)
    );

    always #4 clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_leaf(input logic [`KD_LEAF_WIDTH-1:0] got,
                              input logic [`KD_LEAF_WIDTH-1:0] exp, input int lane);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t ns: lane %0d leaf %0d, expected %0d",
                               $time, lane, got, exp));
        end
    endtask

    task automatic check_word(input node_word_t got, input node_word_t exp, input int addr);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t ns: node %0d idx %0d median %0d, expected %0d %0d",
                               $time, addr, got.idx, got.median, exp.idx, exp.median));
        end
    endtask

    task automatic check_cycle(input int got, input int exp, input int lane);
        if (got != exp) begin
            stop_run($sformatf("Error at %0t ns: lane %0d leaf at cycle %0d, expected cycle %0d",
                               $time, lane, got, exp));
        end
    endtask

    // 31-bit LCG, gap taken from the upper bits
    function automatic int next_gap();
        lcg_state = (lcg_state * 32'd1103515245 + 32'd12345) & 32'h7fffffff;
        return (lcg_state >> 16) % 4;
    endfunction

    // one cycle with every strobe low
    task automatic idle_cycle();
        @(posedge clk);
        patch_valid     <= 1'b0;
        patch_two_valid <= 1'b0;
        node_wr         <= 1'b0;
        load_restart    <= 1'b0;
        cfg_stb         <= 1'b0;
    endtask

    // host strobe, ack due one cycle later; returns read data
    task automatic host_access(input cfg_op_e op, input int addr, input int data,
                               output logic [`KD_ELEM_WIDTH-1:0] rdata);
        idle_cycle();
        cfg_stb  <= 1'b1;
        cfg_op   <= op;
        cfg_addr <= addr[`KD_NODE_ADDR_WIDTH-1:0];
        cfg_data <= data[`KD_ELEM_WIDTH-1:0];
        // strobe taken on the next edge, ack seen at the negedge after it
        ack_due = cyc + 2;
        idle_cycle();
        @(negedge clk);
        if (cfg_ack !== 1'b1) begin
            stop_run("host port gave no acknowledge in the cycle after the strobe");
        end
        rdata = cfg_rdata;
    endtask

    // leaf monitor, each valid cycle is one result
    always @(negedge clk) begin
        if (leaf_valid === 1'b1) begin
            if (exp_q[0].size() == 0) begin
                stop_run("lane 1 gave a leaf with no patch outstanding");
            end
            check_cycle(cyc, due_q[0].pop_front(), 1);
            check_leaf(leaf_index, exp_q[0].pop_front(), 1);
        end
        if (leaf_two_valid === 1'b1) begin
            if (exp_q[1].size() == 0) begin
                stop_run("lane 2 gave a leaf with no patch outstanding");
            end
            check_cycle(cyc, due_q[1].pop_front(), 2);
            check_leaf(leaf_two_index, exp_q[1].pop_front(), 2);
        end
    end

    // ack only right after a strobe, read data zero outside that cycle
    always @(negedge clk) begin
        if (cyc != ack_due) begin
            if (cfg_ack !== 1'b0) begin
                stop_run("host port acknowledge outside the cycle after a strobe");
            end
            if (cfg_rdata !== '0) begin
                stop_run("host port read data not zero outside an acknowledge");
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > limit) begin
            stop_run("run took longer than the cycle limit, DUT or testbench stuck");
        end
    end

    initial begin
        int                        fd;
        int                        nlines;
        int                        n;
        int                        v;
        int                        a;
        int                        med;
        int                        idx;
        int                        drain;
        string                     line;
        byte                       cmd;
        logic [`KD_PATCH_WIDTH-1:0] p [2];
        int                        leaf [2];
        logic [`KD_ELEM_WIDTH-1:0] rd_lo;
        logic [`KD_ELEM_WIDTH-1:0] rd_hi;
        node_word_t                word;

        clk = 1'b0;
        rst_n = 1'b0;
        mode = MODE_STREAM;
        node_wr = 1'b0;
        node_data = '0;
        load_restart = 1'b0;
        cfg_stb = 1'b0;
        cfg_op = CFG_WR_LO;
        cfg_addr = '0;
        cfg_data = '0;
        patch_valid = 1'b0;
        patch = '0;
        patch_two_valid = 1'b0;
        patch_two = '0;

        // count lines to size the cycle limit
        fd = $fopen("testbench/kd_tree_tests.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open testbench/kd_tree_tests.txt");
        end
        nlines = 0;
        while ($fgets(line, fd)) begin
            nlines++;
        end
        $fclose(fd);
        limit = 20 * nlines + 200;
        fd = $fopen("testbench/kd_tree_tests.txt", "r");

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        while ($fscanf(fd, " %c", cmd) == 1) begin
            case (cmd)
                "#": void'($fgets(line, fd));
                "M": begin
                    void'($fscanf(fd, "%d", v));
                    idle_cycle();
                    mode <= load_mode_e'(v[0]);
                end
                "R": begin
                    idle_cycle();
                    load_restart <= 1'b1;
                end
                "S": begin
                    void'($fscanf(fd, "%d %h", n, v));
                    for (int i = 0; i < n; i++) begin
                        idle_cycle();
                        node_wr   <= 1'b1;
                        node_data <= node_word_t'(v);
                    end
                end
                "H": begin
                    void'($fscanf(fd, "%d %d %d", a, med, idx));
                    host_access(CFG_WR_LO, a, med, rd_lo);
                    host_access(CFG_WR_HI, a, idx, rd_hi);
                    // writes return zero read data
                    check_word({rd_hi, rd_lo}, '0, a);
                end
                "Q": begin
                    void'($fscanf(fd, "%d %d %d", a, med, idx));
                    host_access(CFG_RD_LO, a, 0, rd_lo);
                    host_access(CFG_RD_HI, a, 0, rd_hi);
                    word.idx    = idx[`KD_ELEM_WIDTH-1:0];
                    word.median = med[`KD_ELEM_WIDTH-1:0];
                    check_word({rd_hi, rd_lo}, word, a);
                end
                "P": begin
                    for (int l = 0; l < 2; l++) begin
                        for (int e = 0; e < `KD_ELEMS; e++) begin
                            void'($fscanf(fd, "%d", v));
                            p[l][e*`KD_ELEM_WIDTH +: `KD_ELEM_WIDTH] = v[`KD_ELEM_WIDTH-1:0];
                        end
                        void'($fscanf(fd, "%d", leaf[l]));
                    end
                    repeat (next_gap()) idle_cycle();
                    idle_cycle();
                    // strobe sampled on the next edge, leaf seven edges after
                    for (int l = 0; l < 2; l++) begin
                        exp_q[l].push_back(leaf[l]);
                        due_q[l].push_back(cyc + 9);
                    end
                    patch_valid     <= 1'b1;
                    patch           <= p[0];
                    patch_two_valid <= 1'b1;
                    patch_two       <= p[1];
                end
                "W": begin
                    idle_cycle();
                    while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
                        idle_cycle();
                    end
                end
                default: stop_run($sformatf("unknown command '%c' in the tests file", cmd));
            endcase
        end
        $fclose(fd);

        // last patches get a bounded time to leave the pipeline
        idle_cycle();
        drain = 0;
        while ((exp_q[0].size() != 0 || exp_q[1].size() != 0)
               && drain < 2 * `KD_DEPTH + 4) begin
            idle_cycle();
            drain++;
        end
        repeat (2) idle_cycle();
        if (exp_q[0].size() == 0 && exp_q[1].size() == 0) begin
            $display("Simulation PASSED");
        end else begin
            stop_run("leaf results still outstanding at the end of the run");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+design
design/kd_tree_pkg.sv
design/internal_node.sv
design/node_loader.sv
design/internal_node_tree.sv
design/kd_tree_top.sv
testbench/kd_tree_tb.sv

/* Makefile */
# Verilator build and run of the kd-tree search stage testbench

SIM = obj_dir/kd_tree_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log for the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary -Wno-fatal -f src.f --top-module kd_tree_tb -o kd_tree_sim
	-./$(SIM) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* testbench/kd_tree_tests.txt */
# M mode | R | S count word_hex | H addr median idx | Q addr median idx | W
# P e0 e1 e2 e3 e4 leaf (lane one), then e0 e1 e2 e3 e4 leaf (lane two)
# reset tree, every node all zero, always right
P 5 6 7 8 9 63 100 200 300 400 500 63
P 0 0 0 0 0 63 2047 2047 2047 2047 2047 63
W
# stream load, level k splits on element k at 1024, level 5 on element 4 at 1500
M 0
S 1 000400
S 2 000C00
S 4 001400
S 8 001C00
S 16 002400
S 32 002DDC
P 2000 0 2000 0 1600 43 0 2000 0 2000 1100 22
P 0 0 0 0 0 0 2047 2047 2047 2047 2047 63
P 1024 1023 1024 1023 1499 42 1023 1024 1023 1024 1500 23
P 1500 1500 0 0 500 48 0 0 1500 1500 2000 15
P 1100 0 0 1100 1400 38 0 1100 1100 0 0 24
P 2047 0 0 0 0 32 0 0 0 0 1024 2
W
# host port reads and writes
M 1
Q 0 1024 0
Q 62 1500 5
Q 63 0 0
H 10 777 3
Q 10 777 3
# stream strobe ignored in host mode
S 1 3FFFFF
Q 10 777 3
Q 0 1024 0
# root now splits on element 4 at 500
H 0 500 4
Q 0 500 4
P 0 0 2000 800 400 8 0 2000 2000 800 2047 59
P 2047 1500 1500 800 100 28 0 1500 1500 700 499 24
W
# restart, new root and node 1 from address 0
M 0
R
S 1 000700
S 1 000E00
P 1800 1600 0 0 0 48 1700 1600 0 0 0 16
P 1791 1535 2047 2047 2047 15 1792 1535 2047 0 1024 58
W
